// File: common/rr_csr_pkg.sv
package rr_csr_pkg;

    // Register file geometry
    localparam int RR_CSR_CNT = 8;
    localparam int RR_CSR_ADDR_WIDTH = 3;

    // Register indices, one 32-bit word each
    localparam logic [RR_CSR_ADDR_WIDTH-1:0] RR_MODE = 3'd0;
    localparam logic [RR_CSR_ADDR_WIDTH-1:0] BUF_BASE = 3'd1;
    localparam logic [RR_CSR_ADDR_WIDTH-1:0] BUF_SIZE = 3'd2;

    // Writing either of these only fires a one-cycle pulse
    localparam logic [RR_CSR_ADDR_WIDTH-1:0] WRITE_BUF_UPDATE = 3'd3;
    localparam logic [RR_CSR_ADDR_WIDTH-1:0] READ_BUF_UPDATE = 3'd4;

    localparam logic [RR_CSR_ADDR_WIDTH-1:0] REPLAY_COUNT = 3'd5;

    // Loaded from the storage arbiter every cycle, in words
    localparam logic [RR_CSR_ADDR_WIDTH-1:0] RECORD_COUNT = 3'd6;

    // Index 7 is spare

    // Enable bits inside RR_MODE
    localparam int MODE_RECORD_BIT = 0;
    localparam int MODE_REPLAY_BIT = 1;

endpackage

// File: common/rr_trace_pkg.sv
package rr_trace_pkg;

    // Width of one trace word
    localparam int TRACE_W = 32;

    // Trace buffer holds 2**BUF_AW words
    localparam int BUF_AW = 6;

    // Logger FIFO depth, which is also the sender's starting credit count
    localparam int REC_CREDITS = 4;

    // Credits the replay feeder holds out of reset
    localparam int REP_CREDITS = 2;

    // Which request owns the trace buffer this cycle
    typedef enum logic [1:0] {
        op_idle,
        op_write,
        op_read
    } storage_op_e;

    // Side that got the last grant, used to alternate on contention
    typedef enum logic {
        last_rec,
        last_rep
    } arb_state_e;

endpackage

// File: csrs/rr_csrs.sv
`timescale 1ns/1ns

module rr_csrs (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           awvalid,
    input  logic [31:0]                    awaddr,
    output logic                           awready,
    input  logic                           wvalid,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    output logic                           wready,
    output logic                           bvalid,
    output logic [1:0]                     bresp,
    input  logic                           bready,
    input  logic                           arvalid,
    input  logic [31:0]                    araddr,
    output logic                           arready,
    output logic                           rvalid,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    input  logic                           rready,
    output logic                           record_en,
    output logic                           replay_en,
    output logic [rr_trace_pkg::BUF_AW-1:0] buf_base,
    output logic [rr_trace_pkg::BUF_AW:0]   buf_size,
    output logic [rr_trace_pkg::BUF_AW:0]   replay_count,
    output logic                           write_buf_update,
    output logic                           read_buf_update,
    input  logic [rr_trace_pkg::BUF_AW:0]   record_count
);
    import rr_csr_pkg::*;
    import rr_trace_pkg::*;

    logic [31:0] csrs [RR_CSR_CNT];

    logic aw_fire, w_fire, write_fire;
    logic aw_held, w_held;
    logic write_q, write_qq;
    logic b_busy;
    logic [RR_CSR_ADDR_WIDTH-1:0] wr_addr, wr_addr_q;
    logic [31:0] wr_data_q, strb_mask, merged;
    logic wr_is_strobe_q;
    logic ar_fire, r_busy;

    assign aw_fire = awvalid & awready;
    assign w_fire = wvalid & wready;

    // A write is complete once both address and data are in, in any order
    assign write_fire = (aw_fire | aw_held) & (w_fire | w_held);

    // Hold off a channel that is already captured, or while the response is stuck
    assign b_busy = bvalid & ~bready;
    assign awready = ~aw_held & ~b_busy;
    assign wready = ~w_held & ~b_busy;

    assign r_busy = rvalid & ~rready;
    assign arready = ~r_busy;
    assign ar_fire = arvalid & arready;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    assign wr_is_strobe_q = (wr_addr_q == WRITE_BUF_UPDATE) || (wr_addr_q == READ_BUF_UPDATE);

    // Channel tracking, response handshakes and the register array
    always_ff @(posedge clk) begin
        if (~rstn) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            write_q <= 1'b0;
            write_qq <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            for (int i = 0; i < RR_CSR_CNT; i++) begin
                csrs[i] <= '0;
            end
        end else begin
            if (write_fire) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_held <= 1'b1;
                end
                if (w_fire) begin
                    w_held <= 1'b1;
                end
            end

            write_q <= write_fire;
            write_qq <= write_q;

            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid & bready) begin
                bvalid <= 1'b0;
            end

            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid & rready) begin
                rvalid <= 1'b0;
            end

            // Strobe registers are never stored, so they read back as zero
            if (write_qq && !wr_is_strobe_q) begin
                csrs[wr_addr_q] <= merged;
            end

            // Counter mirror overrides any write landing in the same cycle
            csrs[RECORD_COUNT] <= {{(31 - BUF_AW){1'b0}}, record_count};
        end
    end

    // Captured write payload and the byte merge stage
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            // Word-aligned addresses, so bits 1:0 are not part of the index
            wr_addr <= awaddr[2 +: RR_CSR_ADDR_WIDTH];
        end
        if (w_fire) begin
            wr_data_q <= wdata;
            strb_mask <= {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
        end
        wr_addr_q <= wr_addr;
        if (write_q) begin
            merged <= (strb_mask & wr_data_q) | (~strb_mask & csrs[wr_addr]);
        end
        if (ar_fire) begin
            rdata <= csrs[araddr[2 +: RR_CSR_ADDR_WIDTH]];
        end
    end

    assign record_en = csrs[RR_MODE][MODE_RECORD_BIT];
    assign replay_en = csrs[RR_MODE][MODE_REPLAY_BIT];
    assign buf_base = csrs[BUF_BASE][BUF_AW-1:0];
    assign buf_size = csrs[BUF_SIZE][BUF_AW:0];
    assign replay_count = csrs[REPLAY_COUNT][BUF_AW:0];

    // One-cycle pulses, the cycle after the write is accepted
    assign write_buf_update = write_q && (wr_addr == WRITE_BUF_UPDATE);
    assign read_buf_update = write_q && (wr_addr == READ_BUF_UPDATE);

endmodule

// File: verilog/rr_record_logger.sv
`timescale 1ns/1ns

module rr_record_logger (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             record_en,
    input  logic                             rec_valid,
    input  logic [rr_trace_pkg::TRACE_W-1:0] rec_data,
    output logic                             rec_credit,
    output logic                             wr_valid,
    output logic [rr_trace_pkg::TRACE_W-1:0] wr_data,
    input  logic                             wr_ready
);
    import rr_trace_pkg::*;

    logic [TRACE_W-1:0] fifo_mem [REC_CREDITS];
    logic [$clog2(REC_CREDITS)-1:0] wr_ptr, rd_ptr;
    logic [$clog2(REC_CREDITS+1)-1:0] count;
    logic push, drop, pop;

    // Sender only pushes while holding a credit, so the FIFO never overflows
    assign push = rec_valid & record_en;
    assign drop = rec_valid & ~record_en;

    // A drop takes the credit slot this cycle, so the pop waits one cycle
    assign wr_valid = (count != '0) & ~drop;
    assign wr_data = fifo_mem[rd_ptr];
    assign pop = wr_valid & wr_ready;

    always_ff @(posedge clk) begin
        if (~rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rec_credit <= 1'b0;
        end else begin
            // Pointers wrap naturally since the depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            rec_credit <= pop | drop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= rec_data;
        end
    end

endmodule

// File: verilog/rr_replay_feeder.sv
`timescale 1ns/1ns

module rr_replay_feeder (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             rd_valid,
    input  logic [rr_trace_pkg::TRACE_W-1:0] rd_data,
    output logic                             rd_ready,
    output logic                             rep_valid,
    output logic [rr_trace_pkg::TRACE_W-1:0] rep_data,
    input  logic                             rep_credit
);
    import rr_trace_pkg::*;

    logic [$clog2(REP_CREDITS+1)-1:0] credits;
    logic skid_valid;
    logic [TRACE_W-1:0] skid_data;
    logic emit;

    // Only one word of storage, so accept a new one only when it is empty
    assign rd_ready = ~skid_valid;

    // No credits means the word waits in the skid slot
    assign emit = skid_valid & (credits != '0);

    always_ff @(posedge clk) begin
        if (~rstn) begin
            credits <= REP_CREDITS[$clog2(REP_CREDITS+1)-1:0];
            skid_valid <= 1'b0;
            rep_valid <= 1'b0;
        end else begin
            if (rd_valid & rd_ready) begin
                skid_valid <= 1'b1;
            end else if (emit) begin
                skid_valid <= 1'b0;
            end

            // Spend and return can coincide and cancel out
            if (emit && !rep_credit) begin
                credits <= credits - 1'b1;
            end else if (rep_credit && !emit) begin
                credits <= credits + 1'b1;
            end

            rep_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid & rd_ready) begin
            skid_data <= rd_data;
        end
        if (emit) begin
            rep_data <= skid_data;
        end
    end

endmodule

// File: verilog/rr_storage_arbiter.sv
`timescale 1ns/1ns

module rr_storage_arbiter (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             replay_en,
    input  logic [rr_trace_pkg::BUF_AW-1:0]  buf_base,
    input  logic [rr_trace_pkg::BUF_AW:0]    buf_size,
    input  logic [rr_trace_pkg::BUF_AW:0]    replay_count,
    input  logic                             write_buf_update,
    input  logic                             read_buf_update,
    input  logic                             wr_valid,
    input  logic [rr_trace_pkg::TRACE_W-1:0] wr_data,
    output logic                             wr_ready,
    input  logic                             rd_ready,
    output logic                             rd_valid,
    output logic [rr_trace_pkg::TRACE_W-1:0] rd_data,
    output logic [rr_trace_pkg::BUF_AW:0]    record_count
);
    import rr_trace_pkg::*;

    logic [TRACE_W-1:0] buf_mem [2**BUF_AW];
    logic [BUF_AW-1:0] wr_off, rd_off, mem_addr;
    logic [BUF_AW:0] wr_off_inc, rd_off_inc, replayed;
    logic rd_req;
    storage_op_e op;
    arb_state_e last_grant;

    // rd_valid doubles as the read-in-flight flag
    assign rd_req = replay_en & (replayed < replay_count) & ~rd_valid & rd_ready;

    always_comb begin
        op = op_idle;
        if (wr_valid && rd_req) begin
            op = (last_grant == last_rec) ? op_read : op_write;
        end else if (wr_valid) begin
            op = op_write;
        end else if (rd_req) begin
            op = op_read;
        end
    end

    assign wr_ready = (op == op_write);

    // Offsets wrap at buf_size, then the window sits at buf_base mod buffer depth
    assign wr_off_inc = {1'b0, wr_off} + 1'b1;
    assign rd_off_inc = {1'b0, rd_off} + 1'b1;
    assign mem_addr = buf_base + ((op == op_read) ? rd_off : wr_off);

    always_ff @(posedge clk) begin
        if (~rstn) begin
            wr_off <= '0;
            rd_off <= '0;
            replayed <= '0;
            record_count <= '0;
            last_grant <= last_rec;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= (op == op_read);

            if (write_buf_update) begin
                wr_off <= '0;
                record_count <= '0;
            end else if (op == op_write) begin
                wr_off <= (wr_off_inc >= buf_size) ? '0 : wr_off_inc[BUF_AW-1:0];
                if (record_count < buf_size) begin
                    record_count <= record_count + 1'b1;
                end
            end

            if (read_buf_update) begin
                rd_off <= '0;
                replayed <= '0;
            end else if (op == op_read) begin
                rd_off <= (rd_off_inc >= buf_size) ? '0 : rd_off_inc[BUF_AW-1:0];
                replayed <= replayed + 1'b1;
            end

            if (op == op_write) begin
                last_grant <= last_rec;
            end else if (op == op_read) begin
                last_grant <= last_rep;
            end
        end
    end

    // Single-port buffer, one access per cycle
    always_ff @(posedge clk) begin
        if (op == op_write) begin
            buf_mem[mem_addr] <= wr_data;
        end
        if (op == op_read) begin
            rd_data <= buf_mem[mem_addr];
        end
    end

endmodule

// File: verilog/rr_top.sv
`timescale 1ns/1ns

module rr_top (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             awvalid,
    input  logic [31:0]                      awaddr,
    output logic                             awready,
    input  logic                             wvalid,
    input  logic [31:0]                      wdata,
    input  logic [3:0]                       wstrb,
    output logic                             wready,
    output logic                             bvalid,
    output logic [1:0]                       bresp,
    input  logic                             bready,
    input  logic                             arvalid,
    input  logic [31:0]                      araddr,
    output logic                             arready,
    output logic                             rvalid,
    output logic [31:0]                      rdata,
    output logic [1:0]                       rresp,
    input  logic                             rready,
    input  logic                             rec_valid,
    input  logic [rr_trace_pkg::TRACE_W-1:0] rec_data,
    output logic                             rec_credit,
    output logic                             rep_valid,
    output logic [rr_trace_pkg::TRACE_W-1:0] rep_data,
    input  logic                             rep_credit
);
    import rr_trace_pkg::*;

    // Configuration from the register file
    logic record_en, replay_en;
    logic [BUF_AW-1:0] buf_base;
    logic [BUF_AW:0] buf_size, replay_count, record_count;
    logic write_buf_update, read_buf_update;

    // Logger to arbiter, a word moves when the arbiter grants op_write
    logic wr_valid, wr_ready;
    logic [TRACE_W-1:0] wr_data;

    // Arbiter to feeder, rd_valid follows an op_read grant by one cycle
    logic rd_valid, rd_ready;
    logic [TRACE_W-1:0] rd_data;

    rr_csrs i_csrs (
        .clk(clk), .rstn(rstn),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .record_en(record_en), .replay_en(replay_en),
        .buf_base(buf_base), .buf_size(buf_size), .replay_count(replay_count),
        .write_buf_update(write_buf_update), .read_buf_update(read_buf_update),
        .record_count(record_count)
    );

    rr_record_logger i_record_logger (
        .clk(clk), .rstn(rstn), .record_en(record_en),
        .rec_valid(rec_valid), .rec_data(rec_data), .rec_credit(rec_credit),
        .wr_valid(wr_valid), .wr_data(wr_data), .wr_ready(wr_ready)
    );

    rr_storage_arbiter i_storage_arbiter (
        .clk(clk), .rstn(rstn), .replay_en(replay_en),
        .buf_base(buf_base), .buf_size(buf_size), .replay_count(replay_count),
        .write_buf_update(write_buf_update), .read_buf_update(read_buf_update),
        .wr_valid(wr_valid), .wr_data(wr_data), .wr_ready(wr_ready),
        .rd_ready(rd_ready), .rd_valid(rd_valid), .rd_data(rd_data),
        .record_count(record_count)
    );

    rr_replay_feeder i_replay_feeder (
        .clk(clk), .rstn(rstn),
        .rd_valid(rd_valid), .rd_data(rd_data), .rd_ready(rd_ready),
        .rep_valid(rep_valid), .rep_data(rep_data), .rep_credit(rep_credit)
    );

endmodule

// File: tb/rr_clk_gen.sv
`timescale 1ns/1ns

module rr_clk_gen (
    output logic clk,
    output logic rstn
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for the first 10 rising edges
    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

// File: tb/rr_tb.sv
`timescale 1ns/1ns

module rr_tb;
    import rr_csr_pkg::*;
    import rr_trace_pkg::*;

    logic clk, rstn;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic rec_valid, rec_credit, rep_valid, rep_credit;
    logic [TRACE_W-1:0] rec_data, rep_data;

    // Parsed case lines
    string case_kw [$];
    logic [31:0] case_a [$];
    logic [31:0] case_b [$];
    logic [31:0] case_c [$];
    bit cases_loaded = 1'b0;

    // Shadow of the register file and a model of the trace buffer
    logic [31:0] shadow [RR_CSR_CNT];
    logic [TRACE_W-1:0] model_mem [2**BUF_AW];
    int model_woff, model_roff;

    int rec_sent, rec_returned, rep_uncredited;
    logic [TRACE_W-1:0] rep_q [$];
    logic [31:0] lfsr_state;

    rr_clk_gen i_clk_gen (.clk(clk), .rstn(rstn));

    rr_top i_rr_top (.*);

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping simulation");
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    // Window offsets wrap at BUF_SIZE and sit at BUF_BASE mod buffer depth
    function automatic int next_offset(input int off);
        return (off + 1 >= int'(shadow[BUF_SIZE][BUF_AW:0])) ? 0 : off + 1;
    endfunction

    function automatic logic [BUF_AW-1:0] window_addr(input int off);
        return shadow[BUF_BASE][BUF_AW-1:0] + off[BUF_AW-1:0];
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [RR_CSR_ADDR_WIDTH-1:0] idx, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [7:0] order;
        logic aw_pending, w_pending, aw_done, w_done;
        order = take_bits(2);
        aw_pending = 1'b1;
        w_pending = 1'b1;
        awaddr = {27'b0, idx, 2'b00};
        wdata = data;
        wstrb = strb;
        // 1 sends AW first, 2 sends W first, else both together
        awvalid = (order != 8'd2);
        wvalid = (order != 8'd1);
        while (aw_pending || w_pending) begin
            @(negedge clk);
            aw_done = awvalid & awready;
            w_done = wvalid & wready;
            next_cycle();
            if (aw_done) begin
                awvalid = 1'b0;
                aw_pending = 1'b0;
            end
            if (w_done) begin
                wvalid = 1'b0;
                w_pending = 1'b0;
            end
            if (aw_pending && !w_pending) begin
                awvalid = 1'b1;
            end
            if (w_pending && !aw_pending) begin
                wvalid = 1'b1;
            end
        end
        bready = 1'b1;
        @(negedge clk);
        assert (bvalid && bresp == 2'b00) else
            report_error($sformatf("write to register %0d got no OKAY response", idx));
        next_cycle();
        bready = 1'b0;
        // Register value lands two cycles after acceptance
        repeat (2) next_cycle();
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                shadow[idx][8*i +: 8] = data[8*i +: 8];
            end
        end
        if (idx == WRITE_BUF_UPDATE) begin
            model_woff = 0;
        end
        if (idx == READ_BUF_UPDATE) begin
            model_roff = 0;
        end
    endtask

    task automatic axi_read(input logic [RR_CSR_ADDR_WIDTH-1:0] idx, input logic [31:0] expected);
        logic ar_done;
        araddr = {27'b0, idx, 2'b00};
        arvalid = 1'b1;
        ar_done = 1'b0;
        while (!ar_done) begin
            @(negedge clk);
            ar_done = arready;
            next_cycle();
        end
        arvalid = 1'b0;
        rready = 1'b1;
        @(negedge clk);
        assert (rvalid && rresp == 2'b00 && rdata == expected) else
            report_error($sformatf("register %0d rvalid %b rdata %h, expected %h",
                                   idx, rvalid, rdata, expected));
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic record_words(input int n, input logic [31:0] first);
        logic [7:0] gap;
        for (int i = 0; i < n; i++) begin
            // Only push while holding a credit
            while (rec_sent - rec_returned >= REC_CREDITS) begin
                next_cycle();
            end
            rec_valid = 1'b1;
            rec_data = first + i;
            rec_sent++;
            if (shadow[RR_MODE][MODE_RECORD_BIT]) begin
                model_mem[window_addr(model_woff)] = first + i;
                model_woff = next_offset(model_woff);
            end
            next_cycle();
            rec_valid = 1'b0;
            gap = take_bits(1);
            if (gap[0]) begin
                next_cycle();
            end
        end
        // All credits back means the FIFO has drained into the buffer
        while (rec_returned != rec_sent) begin
            next_cycle();
        end
    endtask

    task automatic replay_words(input int n);
        logic [TRACE_W-1:0] got, expected;
        for (int i = 0; i < n; i++) begin
            while (rep_q.size() == 0) begin
                next_cycle();
            end
            got = rep_q.pop_front();
            expected = model_mem[window_addr(model_roff)];
            model_roff = next_offset(model_roff);
            assert (got == expected) else
                report_error($sformatf("replay word %0d is %h, expected %h", i, got, expected));
        end
        while (rep_uncredited != 0) begin
            next_cycle();
        end
        // Quiet window catches words beyond REPLAY_COUNT
        repeat (20) next_cycle();
        assert (rep_q.size() == 0) else
            report_error($sformatf("%0d replay words beyond the expected %0d", rep_q.size(), n));
    endtask

    // Output sampling at the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (rec_credit) begin
                rec_returned++;
            end
            assert (rec_returned <= rec_sent) else
                report_error($sformatf("more record credits than words, sent %0d returned %0d",
                                       rec_sent, rec_returned));
            if (rep_valid) begin
                rep_q.push_back(rep_data);
                rep_uncredited++;
            end
            assert (rep_uncredited <= REP_CREDITS) else
                report_error($sformatf("%0d replay words outstanding", rep_uncredited));
        end
    end

    // Replay consumer returns each credit after 0 to 7 cycles
    initial begin
        logic [7:0] delay;
        wait (rstn === 1'b1);
        forever begin
            next_cycle();
            if (rep_uncredited > 0) begin
                delay = take_bits(3);
                repeat (delay) next_cycle();
                rep_credit = 1'b1;
                next_cycle();
                rep_credit = 1'b0;
                rep_uncredited--;
            end
        end
    end

    initial begin
        wait (cases_loaded);
        #(case_kw.size() * 200 * 10);
        abort_run($sformatf("Timeout after %0d cases, the run did not finish", case_kw.size()));
    end

    initial begin
        int fd, code;
        string line;
        string kw;
        logic [31:0] a, b, c;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        rec_valid = 1'b0;
        rec_data = '0;
        rep_credit = 1'b0;
        rec_sent = 0;
        rec_returned = 0;
        rep_uncredited = 0;
        model_woff = 0;
        model_roff = 0;
        lfsr_state = 32'h048d_954f;
        for (int i = 0; i < RR_CSR_CNT; i++) begin
            shadow[i] = '0;
        end

        fd = $fopen("tb/rr_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tb/rr_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            code = $sscanf(line, "%s %h %h %h", kw, a, b, c);
            if (code >= 1 && kw != "#") begin
                if (code != 4) begin
                    abort_run($sformatf("Malformed line in cases file starting with %s", kw));
                end
                case_kw.push_back(kw);
                case_a.push_back(a);
                case_b.push_back(b);
                case_c.push_back(c);
            end
        end
        $fclose(fd);
        cases_loaded = 1'b1;

        wait (rstn === 1'b1);
        next_cycle();
        foreach (case_kw[k]) begin
            if (case_kw[k] == "write") begin
                axi_write(case_a[k][RR_CSR_ADDR_WIDTH-1:0], case_b[k], case_c[k][3:0]);
            end else if (case_kw[k] == "read") begin
                axi_read(case_a[k][RR_CSR_ADDR_WIDTH-1:0], case_b[k]);
            end else if (case_kw[k] == "record") begin
                record_words(int'(case_a[k]), case_b[k]);
            end else if (case_kw[k] == "replay") begin
                replay_words(int'(case_a[k]));
            end else begin
                abort_run($sformatf("Unknown operation %s in case %0d", case_kw[k], k));
            end
        end

        assert (rep_q.size() == 0) else
            report_error("replay words left over at the end of the run");
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tb/rr_cases.txt
# columns are op a b c, all hex
# write idx data strb | read idx expected 0 | record words first 0 | replay words 0 0
read 0 00000000 0
read 1 00000000 0
read 2 00000000 0
read 3 00000000 0
read 4 00000000 0
read 5 00000000 0
read 6 00000000 0
read 7 00000000 0
write 1 a5a5a53c 1
read 1 0000003c 0
write 1 ffffff00 6
read 1 00ffff3c 0
write 2 00000008 f
write 6 12345678 f
read 6 00000000 0
write 0 00000001 f
write 3 00000000 f
record 5 00001000 0
read 6 00000005 0
write 0 00000000 f
record 3 00003000 0
read 6 00000005 0
write 0 00000001 f
record 6 00002000 0
read 6 00000008 0
write 5 00000008 f
write 4 00000000 f
write 0 00000003 f
replay 8 00000000 0
write 0 00000001 f
write 3 00000000 f
read 6 00000000 0

// File: sim.f
common/rr_csr_pkg.sv
common/rr_trace_pkg.sv
csrs/rr_csrs.sv
verilog/rr_record_logger.sv
verilog/rr_replay_feeder.sv
verilog/rr_storage_arbiter.sv
verilog/rr_top.sv
tb/rr_clk_gen.sv
tb/rr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rr_tb -f sim.f -o rr_sim \
    && ./obj_dir/rr_sim | tee /dev/stderr | grep "TB PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
